//--- source/soc_bus_pkg.sv
// --------------------------------------
// shared bus widths, address map, timer
// register offsets and timebase constants
// --------------------------------------
`default_nettype none

package soc_bus_pkg;

    // bus widths
    localparam int W_ADDR  = 32;
    localparam int W_DATA  = 32;
    localparam int N_HARTS = 2;

    // on-chip word memory
    localparam int SRAM_DEPTH = 1024;
    localparam int SRAM_IDX_W = $clog2(SRAM_DEPTH);

    // --------------------------------------
    // address map
    // --------------------------------------
    // top three address bits pick the region
    localparam logic [W_ADDR-1:0] REGION_MASK = 32'hE000_0000;
    localparam logic [W_ADDR-1:0] SRAM_BASE   = 32'h0000_0000;
    localparam logic [W_ADDR-1:0] TIMER_BASE  = 32'h4000_0000;

    // --------------------------------------
    // machine timer
    // --------------------------------------
    localparam int TMR_OFS_W = 5;
    localparam logic [TMR_OFS_W-1:0] TMR_MTIME_LO = 5'h00;
    localparam logic [TMR_OFS_W-1:0] TMR_MTIME_HI = 5'h04;
    localparam logic [TMR_OFS_W-1:0] TMR_CMP0_LO  = 5'h08;
    localparam logic [TMR_OFS_W-1:0] TMR_CMP0_HI  = 5'h0C;
    localparam logic [TMR_OFS_W-1:0] TMR_CMP1_LO  = 5'h10;
    localparam logic [TMR_OFS_W-1:0] TMR_CMP1_HI  = 5'h14;
    // one software interrupt bit per hart
    localparam logic [TMR_OFS_W-1:0] TMR_MSIP     = 5'h18;

    localparam int MTIME_W = 64;

    // timebase, one tick per microsecond
    localparam int CLK_MHZ = 25;
    localparam int TICK_W  = $clog2(CLK_MHZ);

endpackage

`default_nettype wire

//--- source/sys_bus_if.sv
// --------------------------------------
// shared system bus, one-cycle strobe
// and fixed-latency done
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface sys_bus_if;

    // request side
    logic                            req;
    logic                            write;
    logic [soc_bus_pkg::W_ADDR-1:0]  addr;
    logic [soc_bus_pkg::W_DATA-1:0]  wdata;

    // response side
    logic                            done;
    logic [soc_bus_pkg::W_DATA-1:0]  rdata;

    modport initiator (
        output req, write, addr, wdata,
        input  done, rdata
    );

    modport target (
        input  req, write, addr, wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

//--- source/bus_arbiter.sv
// --------------------------------------
// round-robin arbiter, two hart ports
// onto the shared system bus
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire                             clk,
    input  wire                             rst_n,

    // hart 0 port
    input  wire                             i_m0_req,
    input  wire                             i_m0_write,
    input  wire [soc_bus_pkg::W_ADDR-1:0]   i_m0_addr,
    input  wire [soc_bus_pkg::W_DATA-1:0]   i_m0_wdata,
    output logic                            o_m0_done,
    output logic [soc_bus_pkg::W_DATA-1:0]  o_m0_rdata,

    // hart 1 port
    input  wire                             i_m1_req,
    input  wire                             i_m1_write,
    input  wire [soc_bus_pkg::W_ADDR-1:0]   i_m1_addr,
    input  wire [soc_bus_pkg::W_DATA-1:0]   i_m1_wdata,
    output logic                            o_m1_done,
    output logic [soc_bus_pkg::W_DATA-1:0]  o_m1_rdata,

    sys_bus_if.initiator                    bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_DONE
    } arb_state_t;

    arb_state_t                       state;
    logic                             gnt_m1;
    // set when hart 1 wins a tie
    logic                             prio_m1;
    logic                             any_req;
    logic                             pick_m1;
    logic                             grant;
    logic [soc_bus_pkg::W_DATA-1:0]   rdata_q;

    assign any_req = i_m0_req | i_m1_req;
    assign pick_m1 = i_m1_req & (~i_m0_req | prio_m1);
    // requests only sampled while idle
    assign grant   = (state == ST_IDLE) & any_req;

    // --------------------------------------
    // control FSM
    // --------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            gnt_m1    <= 1'b0;
            prio_m1   <= 1'b0;
            bus.req   <= 1'b0;
            o_m0_done <= 1'b0;
            o_m1_done <= 1'b0;
        end else begin
            bus.req   <= 1'b0;
            o_m0_done <= 1'b0;
            o_m1_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (grant) begin
                        state   <= ST_WAIT;
                        gnt_m1  <= pick_m1;
                        // priority passes to the other hart
                        prio_m1 <= ~pick_m1;
                        bus.req <= 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (bus.done) begin
                        state     <= ST_DONE;
                        o_m0_done <= ~gnt_m1;
                        o_m1_done <= gnt_m1;
                    end
                end
                ST_DONE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------
    // payload
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (grant) begin
            bus.write <= pick_m1 ? i_m1_write : i_m0_write;
            bus.addr  <= pick_m1 ? i_m1_addr  : i_m0_addr;
            bus.wdata <= pick_m1 ? i_m1_wdata : i_m0_wdata;
        end
        if ((state == ST_WAIT) && bus.done) begin
            rdata_q <= bus.rdata;
        end
    end

    // only the granted hart sees done, so rdata can be shared
    assign o_m0_rdata = rdata_q;
    assign o_m1_rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/bus_decoder.sv
// --------------------------------------
// address decoder, SRAM / timer / unmapped
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire           clk,
    input  wire           rst_n,
    sys_bus_if.target     arb_bus,
    sys_bus_if.initiator  sram_bus,
    sys_bus_if.initiator  tmr_bus
);

    logic [soc_bus_pkg::W_ADDR-1:0] region;
    logic                           sel_sram;
    logic                           sel_tmr;
    logic                           unm_done;

    assign region   = arb_bus.addr & soc_bus_pkg::REGION_MASK;
    assign sel_sram = (region == soc_bus_pkg::SRAM_BASE);
    assign sel_tmr  = (region == soc_bus_pkg::TIMER_BASE);

    // --------------------------------------
    // request fan-out
    // --------------------------------------
    assign sram_bus.req   = arb_bus.req & sel_sram;
    assign sram_bus.write = arb_bus.write;
    assign sram_bus.addr  = arb_bus.addr;
    assign sram_bus.wdata = arb_bus.wdata;

    assign tmr_bus.req    = arb_bus.req & sel_tmr;
    assign tmr_bus.write  = arb_bus.write;
    assign tmr_bus.addr   = arb_bus.addr;
    assign tmr_bus.wdata  = arb_bus.wdata;

    // unmapped space answers itself, writes dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            unm_done <= 1'b0;
        end else begin
            unm_done <= arb_bus.req & ~sel_sram & ~sel_tmr;
        end
    end

    // --------------------------------------
    // response merge
    // --------------------------------------
    // one access in flight, so done picks the source
    assign arb_bus.done = sram_bus.done | tmr_bus.done | unm_done;

    always_comb begin
        if (sram_bus.done) begin
            arb_bus.rdata = sram_bus.rdata;
        end else if (tmr_bus.done) begin
            arb_bus.rdata = tmr_bus.rdata;
        end else begin
            arb_bus.rdata = '0;
        end
    end

endmodule

`default_nettype wire

//--- source/sram_store.sv
// --------------------------------------
// on-chip word SRAM, one-cycle response
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sram_store (
    input  wire        clk,
    sys_bus_if.target  bus
);

    logic [soc_bus_pkg::W_DATA-1:0]     mem [soc_bus_pkg::SRAM_DEPTH];
    logic [soc_bus_pkg::SRAM_IDX_W-1:0] idx;

    // word index from the byte address
    assign idx = bus.addr[soc_bus_pkg::SRAM_IDX_W+1:2];

    // read-before-write, a write returns the old word
    always_ff @(posedge clk) begin
        if (bus.req) begin
            bus.rdata <= mem[idx];
            if (bus.write) begin
                mem[idx] <= bus.wdata;
            end
        end
    end

    // req is held low through reset, so done settles low
    always_ff @(posedge clk) begin
        bus.done <= bus.req;
    end

endmodule

`default_nettype wire

//--- source/machine_timer.sv
// --------------------------------------
// RISC-V machine timer, mtime, mtimecmp
// and msip per hart, microsecond tick
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module machine_timer (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire                               i_halt,
    sys_bus_if.target                         bus,
    output logic [soc_bus_pkg::N_HARTS-1:0]   o_timer_irq,
    output logic [soc_bus_pkg::N_HARTS-1:0]   o_soft_irq
);

    localparam int TW = soc_bus_pkg::TICK_W;
    localparam int MW = soc_bus_pkg::MTIME_W;
    localparam int DW = soc_bus_pkg::W_DATA;

    logic [TW-1:0]                      tick_ctr;
    logic                               tick;
    logic [MW-1:0]                      mtime;
    logic [MW-1:0]                      mtimecmp [soc_bus_pkg::N_HARTS];
    logic [soc_bus_pkg::N_HARTS-1:0]    msip;
    logic [soc_bus_pkg::TMR_OFS_W-1:0]  reg_ofs;
    logic                               wr_en;
    logic [DW-1:0]                      rd_word;

    assign reg_ofs = bus.addr[soc_bus_pkg::TMR_OFS_W-1:0];
    assign wr_en   = bus.req & bus.write;

    // --------------------------------------
    // microsecond tick
    // --------------------------------------
    assign tick = (tick_ctr == '0) & ~i_halt;

    // divider holds while the harts are halted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_ctr <= TW'(soc_bus_pkg::CLK_MHZ - 1);
        end else if (!i_halt) begin
            if (tick_ctr == '0) begin
                tick_ctr <= TW'(soc_bus_pkg::CLK_MHZ - 1);
            end else begin
                tick_ctr <= tick_ctr - TW'(1);
            end
        end
    end

    // bus write wins over the tick increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (wr_en && (reg_ofs == soc_bus_pkg::TMR_MTIME_LO)) begin
            mtime[DW-1:0] <= bus.wdata;
        end else if (wr_en && (reg_ofs == soc_bus_pkg::TMR_MTIME_HI)) begin
            mtime[MW-1:DW] <= bus.wdata;
        end else if (tick) begin
            mtime <= mtime + MW'(1);
        end
    end

    // --------------------------------------
    // compare and msip registers
    // --------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int h = 0; h < soc_bus_pkg::N_HARTS; h++) begin
                mtimecmp[h] <= '1;
            end
            msip <= '0;
        end else if (wr_en) begin
            case (reg_ofs)
                soc_bus_pkg::TMR_CMP0_LO: mtimecmp[0][DW-1:0]  <= bus.wdata;
                soc_bus_pkg::TMR_CMP0_HI: mtimecmp[0][MW-1:DW] <= bus.wdata;
                soc_bus_pkg::TMR_CMP1_LO: mtimecmp[1][DW-1:0]  <= bus.wdata;
                soc_bus_pkg::TMR_CMP1_HI: mtimecmp[1][MW-1:DW] <= bus.wdata;
                soc_bus_pkg::TMR_MSIP:    msip <= bus.wdata[soc_bus_pkg::N_HARTS-1:0];
                default: begin
                end
            endcase
        end
    end

    // --------------------------------------
    // register read
    // --------------------------------------
    always_comb begin
        case (reg_ofs)
            soc_bus_pkg::TMR_MTIME_LO: rd_word = mtime[DW-1:0];
            soc_bus_pkg::TMR_MTIME_HI: rd_word = mtime[MW-1:DW];
            soc_bus_pkg::TMR_CMP0_LO:  rd_word = mtimecmp[0][DW-1:0];
            soc_bus_pkg::TMR_CMP0_HI:  rd_word = mtimecmp[0][MW-1:DW];
            soc_bus_pkg::TMR_CMP1_LO:  rd_word = mtimecmp[1][DW-1:0];
            soc_bus_pkg::TMR_CMP1_HI:  rd_word = mtimecmp[1][MW-1:DW];
            soc_bus_pkg::TMR_MSIP:     rd_word = DW'(msip);
            default:                   rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.req) begin
            bus.rdata <= rd_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.done <= 1'b0;
        end else begin
            bus.done <= bus.req;
        end
    end

    // interrupt outputs
    always_comb begin
        for (int h = 0; h < soc_bus_pkg::N_HARTS; h++) begin
            o_timer_irq[h] = (mtime >= mtimecmp[h]);
        end
    end

    assign o_soft_irq = msip;

endmodule

`default_nettype wire

//--- source/soc_bus_top.sv
// --------------------------------------
// dual-hart SoC bus, arbiter, decoder,
// SRAM and machine timer
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              i_halt,

    // hart 0 master port
    input  wire                              i_m0_req,
    input  wire                              i_m0_write,
    input  wire [soc_bus_pkg::W_ADDR-1:0]    i_m0_addr,
    input  wire [soc_bus_pkg::W_DATA-1:0]    i_m0_wdata,
    output wire                              o_m0_done,
    output wire [soc_bus_pkg::W_DATA-1:0]    o_m0_rdata,

    // hart 1 master port
    input  wire                              i_m1_req,
    input  wire                              i_m1_write,
    input  wire [soc_bus_pkg::W_ADDR-1:0]    i_m1_addr,
    input  wire [soc_bus_pkg::W_DATA-1:0]    i_m1_wdata,
    output wire                              o_m1_done,
    output wire [soc_bus_pkg::W_DATA-1:0]    o_m1_rdata,

    // per-hart interrupts
    output wire [soc_bus_pkg::N_HARTS-1:0]   o_timer_irq,
    output wire [soc_bus_pkg::N_HARTS-1:0]   o_soft_irq
);

    sys_bus_if arb_bus ();
    sys_bus_if sram_bus ();
    sys_bus_if tmr_bus ();

    bus_arbiter u_bus_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_m0_req   (i_m0_req),
        .i_m0_write (i_m0_write),
        .i_m0_addr  (i_m0_addr),
        .i_m0_wdata (i_m0_wdata),
        .o_m0_done  (o_m0_done),
        .o_m0_rdata (o_m0_rdata),
        .i_m1_req   (i_m1_req),
        .i_m1_write (i_m1_write),
        .i_m1_addr  (i_m1_addr),
        .i_m1_wdata (i_m1_wdata),
        .o_m1_done  (o_m1_done),
        .o_m1_rdata (o_m1_rdata),
        .bus        (arb_bus)
    );

    bus_decoder u_bus_decoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .arb_bus  (arb_bus),
        .sram_bus (sram_bus),
        .tmr_bus  (tmr_bus)
    );

    sram_store u_sram_store (
        .clk (clk),
        .bus (sram_bus)
    );

    machine_timer u_machine_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_halt      (i_halt),
        .bus         (tmr_bus),
        .o_timer_irq (o_timer_irq),
        .o_soft_irq  (o_soft_irq)
    );

endmodule

`default_nettype wire

//--- bench/tb_bus_tasks.svh
// --------------------------------------
// master port access tasks, timed waits
// and the Galois LFSR for test data
// --------------------------------------
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// right-shift Galois form, taps x^32 x^31 x^29 x^1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'hD000_0001;
    end
    return n;
endfunction

// one step per bit taken
function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        w = {w[30:0], lfsr_state[0]};
    end
    return w;
endfunction

task automatic drive_port(input int m, input logic rq, input logic wr,
                          input logic [31:0] a, input logic [31:0] d);
    if (m == 0) begin
        m0_req   = rq;
        m0_write = wr;
        m0_addr  = a;
        m0_wdata = d;
    end else begin
        m1_req   = rq;
        m1_write = wr;
        m1_addr  = a;
        m1_wdata = d;
    end
endtask

// request held until done, sampled mid-cycle
task automatic bus_access(input int m, input logic wr, input logic [31:0] a,
                          input logic [31:0] d, output logic [31:0] rd);
    int   n;
    logic seen;
    n    = 0;
    seen = 1'b0;
    rd   = '0;
    @(negedge clk);
    drive_port(m, 1'b1, wr, a, d);
    while (!seen && n < ACCESS_TIMEOUT) begin
        @(negedge clk);
        n++;
        seen = (m == 0) ? m0_done : m1_done;
    end
    if (seen) begin
        rd = (m == 0) ? m0_rdata : m1_rdata;
    end else begin
        $display("timeout: master m%0d never completed its access to %h", m, a);
        timed_out = 1'b1;
    end
    drive_port(m, 1'b0, 1'b0, '0, '0);
endtask

// both requests raised on the same falling edge
task automatic dual_access(input logic wr, input logic [31:0] a0, input logic [31:0] d0,
                           input logic [31:0] a1, input logic [31:0] d1,
                           output logic [31:0] r0, output logic [31:0] r1, output int first);
    int   n;
    logic s0;
    logic s1;
    n     = 0;
    s0    = 1'b0;
    s1    = 1'b0;
    r0    = '0;
    r1    = '0;
    first = -1;
    @(negedge clk);
    drive_port(0, 1'b1, wr, a0, d0);
    drive_port(1, 1'b1, wr, a1, d1);
    while (!(s0 && s1) && n < 2 * ACCESS_TIMEOUT) begin
        @(negedge clk);
        n++;
        if (!s0 && m0_done) begin
            s0 = 1'b1;
            r0 = m0_rdata;
            drive_port(0, 1'b0, 1'b0, '0, '0);
            if (first < 0) first = 0;
        end
        if (!s1 && m1_done) begin
            s1 = 1'b1;
            r1 = m1_rdata;
            drive_port(1, 1'b0, 1'b0, '0, '0);
            if (first < 0) first = 1;
        end
    end
    if (!s0 || !s1) begin
        $display("timeout: master m%0d never completed its contended access", s0 ? 1 : 0);
        timed_out = 1'b1;
    end
    drive_port(0, 1'b0, 1'b0, '0, '0);
    drive_port(1, 1'b0, 1'b0, '0, '0);
endtask

task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
        @(negedge clk);
    end
endtask

// timer interrupt pattern, bounded by a cycle limit
task automatic wait_timer_irq(input logic [1:0] exp, input int limit, output logic ok);
    int n;
    n  = 0;
    ok = (timer_irq == exp);
    while (!ok && n < limit) begin
        @(negedge clk);
        n++;
        ok = (timer_irq == exp);
    end
endtask

`endif

//--- bench/tb_soc_bus.sv
// --------------------------------------
// testbench for the dual-hart SoC bus
// --------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

    localparam int ACCESS_TIMEOUT = 100;
    localparam logic [31:0] TB = soc_bus_pkg::TIMER_BASE;
    localparam logic [31:0] LAST_WORD = (soc_bus_pkg::SRAM_DEPTH - 1) * 4;

    typedef enum int {OP_WR, OP_RD, OP_DUAL_WR, OP_DUAL_RD, OP_WAIT, OP_HALT,
                      OP_IRQ_WAIT, OP_CHK_IRQ} op_t;
    typedef enum int {DS_LIT, DS_RAND, DS_LAST} src_t;
    typedef enum int {CK_NONE, CK_EXACT, CK_SHADOW, CK_RANGE, CK_SAME} chk_t;

    logic clk, rst_n, halt;
    logic m0_req, m0_write, m1_req, m1_write;
    logic [31:0] m0_addr, m0_wdata, m1_addr, m1_wdata;
    wire         m0_done, m1_done;
    wire  [31:0] m0_rdata, m1_rdata;
    wire  [1:0]  timer_irq, soft_irq;

    logic [31:0] lfsr_state = 32'he1b13a45;
    logic        timed_out = 1'b0;
    logic [31:0] last_rd = '0;
    logic [31:0] shadow [logic [31:0]];
    int          test_errs = 0;
    int          n_ok = 0;
    int          n_bad = 0;

    // stimulus table with one column per field
    int t_test[$], t_m[$], t_op[$], t_src[$], t_chk[$];
    logic [31:0] t_a0[$], t_a1[$], t_d[$], t_e[$], t_ehi[$];
    string names [1:5] = '{"sram read-back", "unmapped space", "arbitration order",
                           "timebase", "compare and software interrupts"};

    `include "tb_bus_tasks.svh"

    soc_bus_top u_soc_bus_top (
        .clk(clk), .rst_n(rst_n), .i_halt(halt),
        .i_m0_req(m0_req), .i_m0_write(m0_write), .i_m0_addr(m0_addr),
        .i_m0_wdata(m0_wdata), .o_m0_done(m0_done), .o_m0_rdata(m0_rdata),
        .i_m1_req(m1_req), .i_m1_write(m1_write), .i_m1_addr(m1_addr),
        .i_m1_wdata(m1_wdata), .o_m1_done(m1_done), .o_m1_rdata(m1_rdata),
        .o_timer_irq(timer_irq), .o_soft_irq(soft_irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic add(input int tst, input int op, input int m, input logic [31:0] a0,
                       input logic [31:0] a1, input int src, input logic [31:0] d,
                       input int chk, input logic [31:0] e, input logic [31:0] ehi);
        t_test.push_back(tst);
        t_op.push_back(op);
        t_m.push_back(m);
        t_a0.push_back(a0);
        t_a1.push_back(a1);
        t_src.push_back(src);
        t_d.push_back(d);
        t_chk.push_back(chk);
        t_e.push_back(e);
        t_ehi.push_back(ehi);
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s read %h, expected %h", $time, what, got, exp);
            test_errs++;
        end
    endtask

    task automatic record_write(input logic [31:0] a, input logic [31:0] d);
        if ((a & soc_bus_pkg::REGION_MASK) == soc_bus_pkg::SRAM_BASE) begin
            shadow[a] = d;
        end
    endtask

    task automatic run_entry(input int i);
        logic [31:0] d, rd, r0, r1, d1;
        int          first;
        logic        ok;
        case (t_src[i])
            DS_RAND: d = rand_word();
            DS_LAST: d = last_rd + t_d[i];
            default: d = t_d[i];
        endcase
        case (t_op[i])
            OP_WR: begin
                bus_access(t_m[i], 1'b1, t_a0[i], d, rd);
                record_write(t_a0[i], d);
            end
            OP_RD: begin
                bus_access(t_m[i], 1'b0, t_a0[i], '0, rd);
                case (t_chk[i])
                    CK_EXACT:  check_val("exact", rd, t_e[i]);
                    CK_SHADOW: check_val("sram word", rd, shadow[t_a0[i]]);
                    CK_SAME:   check_val("halted mtime", rd, last_rd);
                    CK_RANGE: begin
                        assert (rd >= t_e[i] && rd <= t_ehi[i]) else begin
                            $display("** Error at %0t: mtime %0d outside %0d..%0d",
                                     $time, rd, t_e[i], t_ehi[i]);
                            test_errs++;
                        end
                    end
                    default: ;
                endcase
                last_rd = rd;
            end
            OP_DUAL_WR, OP_DUAL_RD: begin
                d1 = (t_op[i] == OP_DUAL_WR) ? rand_word() : '0;
                dual_access(t_op[i] == OP_DUAL_WR, t_a0[i], d, t_a1[i], d1, r0, r1, first);
                if (t_op[i] == OP_DUAL_WR) begin
                    record_write(t_a0[i], d);
                    record_write(t_a1[i], d1);
                end else begin
                    check_val("m0 contended", r0, shadow[t_a0[i]]);
                    check_val("m1 contended", r1, shadow[t_a1[i]]);
                end
                check_val("first completer", first, t_e[i]);
            end
            OP_WAIT: wait_cycles(t_d[i]);
            OP_HALT: begin
                @(negedge clk);
                halt = t_d[i][0];
            end
            OP_IRQ_WAIT: begin
                wait_timer_irq(t_e[i][1:0], t_d[i], ok);
                assert (ok) else begin
                    $display("timer interrupt never reached %b within %0d cycles",
                             t_e[i][1:0], t_d[i]);
                    test_errs++;
                end
            end
            default: begin
                check_val("irq lines", {28'd0, soft_irq, timer_irq}, t_e[i]);
            end
        endcase
    endtask

    task automatic build_table();
        // arbitration runs first so the first contention sees reset priority
        add(3, OP_DUAL_WR, 0, 32'h100, 32'h104, DS_RAND, 0, CK_NONE, 0, 0);
        add(3, OP_DUAL_RD, 0, 32'h100, 32'h104, DS_LIT, 0, CK_NONE, 0, 0);
        add(3, OP_WR, 0, 32'h108, 0, DS_RAND, 0, CK_NONE, 0, 0);
        add(3, OP_DUAL_WR, 0, 32'h10C, 32'h110, DS_RAND, 0, CK_NONE, 1, 0);
        add(3, OP_DUAL_RD, 0, 32'h110, 32'h10C, DS_LIT, 0, CK_NONE, 1, 0);
        add(3, OP_WR, 1, 32'h114, 0, DS_RAND, 0, CK_NONE, 0, 0);
        add(3, OP_DUAL_RD, 0, 32'h108, 32'h114, DS_LIT, 0, CK_NONE, 0, 0);
        add(1, OP_WR, 0, 32'h0, 0, DS_RAND, 0, CK_NONE, 0, 0);
        add(1, OP_WR, 0, LAST_WORD, 0, DS_RAND, 0, CK_NONE, 0, 0);
        add(1, OP_WR, 0, 32'h200, 0, DS_RAND, 0, CK_NONE, 0, 0);
        add(1, OP_WR, 1, 32'h204, 0, DS_RAND, 0, CK_NONE, 0, 0);
        add(1, OP_WR, 1, 32'h0, 0, DS_RAND, 0, CK_NONE, 0, 0);
        add(1, OP_RD, 1, 32'h0, 0, DS_LIT, 0, CK_SHADOW, 0, 0);
        add(1, OP_RD, 1, LAST_WORD, 0, DS_LIT, 0, CK_SHADOW, 0, 0);
        add(1, OP_RD, 0, 32'h204, 0, DS_LIT, 0, CK_SHADOW, 0, 0);
        add(1, OP_RD, 0, 32'h200, 0, DS_LIT, 0, CK_SHADOW, 0, 0);
        add(1, OP_RD, 0, 32'h0, 0, DS_LIT, 0, CK_SHADOW, 0, 0);
        add(2, OP_RD, 0, 32'h8000_0000, 0, DS_LIT, 0, CK_EXACT, 0, 0);
        add(2, OP_WR, 1, 32'h8000_0000, 0, DS_LIT, 32'hDEAD_BEEF, CK_NONE, 0, 0);
        // low bits line up with the mtimecmp1 offset
        add(2, OP_WR, 0, 32'h8000_0010, 0, DS_LIT, 32'hDEAD_BEEF, CK_NONE, 0, 0);
        add(2, OP_RD, 0, 32'h0, 0, DS_LIT, 0, CK_SHADOW, 0, 0);
        add(2, OP_RD, 1, TB + soc_bus_pkg::TMR_CMP1_LO, 0, DS_LIT, 0, CK_EXACT, '1, 0);
        add(2, OP_RD, 1, 32'h8000_0004, 0, DS_LIT, 0, CK_EXACT, 0, 0);
        add(4, OP_WR, 0, TB + soc_bus_pkg::TMR_MTIME_LO, 0, DS_LIT, 0, CK_NONE, 0, 0);
        add(4, OP_WAIT, 0, 0, 0, DS_LIT, 250, CK_NONE, 0, 0);
        add(4, OP_RD, 1, TB + soc_bus_pkg::TMR_MTIME_LO, 0, DS_LIT, 0, CK_RANGE,
            250 / soc_bus_pkg::CLK_MHZ, 250 / soc_bus_pkg::CLK_MHZ + 1);
        add(4, OP_HALT, 0, 0, 0, DS_LIT, 1, CK_NONE, 0, 0);
        add(4, OP_RD, 0, TB + soc_bus_pkg::TMR_MTIME_LO, 0, DS_LIT, 0, CK_NONE, 0, 0);
        add(4, OP_WAIT, 0, 0, 0, DS_LIT, 300, CK_NONE, 0, 0);
        add(4, OP_RD, 1, TB + soc_bus_pkg::TMR_MTIME_LO, 0, DS_LIT, 0, CK_SAME, 0, 0);
        add(4, OP_HALT, 0, 0, 0, DS_LIT, 0, CK_NONE, 0, 0);
        // irq pattern packs soft bits above the timer bits
        add(5, OP_CHK_IRQ, 0, 0, 0, DS_LIT, 0, CK_NONE, 4'b0000, 0);
        add(5, OP_RD, 0, TB + soc_bus_pkg::TMR_MTIME_LO, 0, DS_LIT, 0, CK_NONE, 0, 0);
        add(5, OP_WR, 0, TB + soc_bus_pkg::TMR_CMP0_HI, 0, DS_LIT, 0, CK_NONE, 0, 0);
        add(5, OP_WR, 0, TB + soc_bus_pkg::TMR_CMP0_LO, 0, DS_LAST, 5, CK_NONE, 0, 0);
        add(5, OP_IRQ_WAIT, 0, 0, 0, DS_LIT, 400, CK_NONE, 2'b01, 0);
        add(5, OP_WAIT, 0, 0, 0, DS_LIT, 100, CK_NONE, 0, 0);
        add(5, OP_CHK_IRQ, 0, 0, 0, DS_LIT, 0, CK_NONE, 4'b0001, 0);
        add(5, OP_WR, 1, TB + soc_bus_pkg::TMR_CMP0_LO, 0, DS_LAST, 100000, CK_NONE, 0, 0);
        add(5, OP_CHK_IRQ, 0, 0, 0, DS_LIT, 0, CK_NONE, 4'b0000, 0);
        add(5, OP_WR, 1, TB + soc_bus_pkg::TMR_MSIP, 0, DS_LIT, 3, CK_NONE, 0, 0);
        add(5, OP_CHK_IRQ, 0, 0, 0, DS_LIT, 0, CK_NONE, 4'b1100, 0);
        add(5, OP_WR, 0, TB + soc_bus_pkg::TMR_MSIP, 0, DS_LIT, 1, CK_NONE, 0, 0);
        add(5, OP_CHK_IRQ, 0, 0, 0, DS_LIT, 0, CK_NONE, 4'b0100, 0);
    endtask

    task automatic report_test(input int tst);
        if (test_errs == 0 && !timed_out) begin
            $display("behavior %0d (%s): ok", tst, names[tst]);
            n_ok++;
        end else begin
            $display("behavior %0d (%s): FAILED, %0d errors", tst, names[tst], test_errs);
            n_bad++;
        end
        test_errs = 0;
    endtask

    initial begin
        int cur;
        rst_n = 1'b0;
        halt  = 1'b0;
        drive_port(0, 1'b0, 1'b0, '0, '0);
        drive_port(1, 1'b0, 1'b0, '0, '0);
        build_table();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        cur = t_test[0];
        for (int i = 0; i < t_op.size(); i++) begin
            if (t_test[i] != cur) begin
                report_test(cur);
                cur = t_test[i];
            end
            run_entry(i);
            if (timed_out) break;
        end
        report_test(cur);
        $display("%0d behaviors ok, %0d behaviors FAILED", n_ok, n_bad);
        if (n_bad == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+bench
source/soc_bus_pkg.sv
source/sys_bus_if.sv
source/bus_arbiter.sv
source/bus_decoder.sv
source/sram_store.sv
source/machine_timer.sv
source/soc_bus_top.sv
bench/tb_soc_bus.sv
